/* Bender.yml */
package:
  name: fetch_stage

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - icache.sv
      - branch_predictor.sv
      - inst_decoder.sv
      - fetch_stage.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_fetch.sv

/* branch_predictor.sv */
// BTB with 2-bit bimodal counters, FETCH_WIDTH query ports and one update port
`timescale 1ns/1ns
`include "fetch_consts.svh"

module branch_predictor import fetch_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  addr_t [`FETCH_WIDTH-1:0] query_pc,
    input  bp_update_t               update,
    output logic  [`FETCH_WIDTH-1:0] pred_taken,
    output addr_t [`FETCH_WIDTH-1:0] pred_target
);
    localparam int IDX_BITS = $clog2(`BP_ENTRIES);
    localparam int TAG_BITS = 32 - IDX_BITS - 2;   // Word aligned PCs

    logic [`BP_ENTRIES-1:0] entry_valid;
    logic [TAG_BITS-1:0]    entry_tag    [`BP_ENTRIES];
    addr_t                  entry_target [`BP_ENTRIES];
    logic [1:0]             entry_ctr    [`BP_ENTRIES];   // 0,1 not taken; 2,3 taken
    logic [IDX_BITS-1:0]    upd_idx;
    logic [TAG_BITS-1:0]    upd_tag;
    logic                   upd_hit;

    //////////////////////////////
    // Query ports

    for (genvar k = 0; k < `FETCH_WIDTH; k++) begin : g_query
        logic [IDX_BITS-1:0] q_idx;
        logic                q_hit;

        assign q_idx          = query_pc[k][IDX_BITS+1:2];
        assign q_hit          = entry_valid[q_idx] &&
                                (entry_tag[q_idx] == query_pc[k][31 -: TAG_BITS]);
        assign pred_taken[k]  = q_hit && entry_ctr[q_idx][1];   // Counter >= 2
        assign pred_target[k] = entry_target[q_idx];
    end

    //////////////////////////////
    // Update port

    assign upd_idx = update.pc[IDX_BITS+1:2];
    assign upd_tag = update.pc[31 -: TAG_BITS];
    assign upd_hit = entry_valid[upd_idx] && (entry_tag[upd_idx] == upd_tag);

    always_ff @(posedge clock) begin
        if (reset)             entry_valid          <= '0;
        else if (update.valid) entry_valid[upd_idx] <= 1'b1;
    end

    always_ff @(posedge clock) begin
        if (update.valid) begin
            entry_tag[upd_idx]    <= upd_tag;
            entry_target[upd_idx] <= update.target;   // Latest target wins
            if (!upd_hit) begin
                entry_ctr[upd_idx] <= update.taken ? 2'd2 : 2'd1;   // Weak start
            end else if (update.taken && entry_ctr[upd_idx] != 2'd3) begin
                entry_ctr[upd_idx] <= entry_ctr[upd_idx] + 2'd1;
            end else if (!update.taken && entry_ctr[upd_idx] != 2'd0) begin
                entry_ctr[upd_idx] <= entry_ctr[upd_idx] - 2'd1;
            end
        end
    end

endmodule

/* fetch_consts.svh */
// Fetch width, I-cache geometry, predictor size, reset PC and NOP encoding
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

//////////////////////////////
// Bundle

`define FETCH_WIDTH        3            // Slots per bundle, oldest in slot 0

//////////////////////////////
// Instruction cache

`define ICACHE_LINE_BYTES  16           // Four words per line
`define ICACHE_LINES       32           // Direct mapped, 512 bytes total

//////////////////////////////
// Branch predictor

`define BP_ENTRIES         16           // BTB entries, indexed by PC word bits

//////////////////////////////
// Architectural constants

`define FETCH_RESET_PC     32'h0000_0000
`define NOP_INST           32'h0000_0013  // addi x0, x0, 0

`endif

/* fetch_pkg.sv */
// Address, instruction, decode, bundle, predictor-update and memory packet types
`include "fetch_consts.svh"

package fetch_pkg;

    //////////////////////////////
    // Basic words

    typedef logic [31:0] addr_t;      // Byte address
    typedef logic [31:0] inst_t;      // One RV32I instruction
    typedef logic [4:0]  reg_idx_t;   // Architectural register

    //////////////////////////////
    // Decode fields

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,
        OPA_ZERO                      // lui, immediate CSR forms
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_RS2,
        OPB_I_IMM,
        OPB_S_IMM,
        OPB_B_IMM,
        OPB_U_IMM,
        OPB_J_IMM
    } opb_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_func_e;

    typedef struct packed {
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        alu_func_e alu_func;
        logic      uses_rs1;
        logic      uses_rs2;
        logic      uses_rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;                // Zero when uses_rd is low
        logic      rd_mem;            // Load
        logic      wr_mem;            // Store
        logic      cond_branch;
        logic      uncond_branch;     // jal, jalr
        logic      csr_op;
        logic      halt;              // ecall, ebreak
        logic      mult;
        logic      illegal;
    } decode_t;

    //////////////////////////////
    // Fetch to dispatch

    typedef struct packed {
        logic    valid;
        addr_t   pc;
        inst_t   inst;
        decode_t decode;
    } fetch_slot_t;

    typedef fetch_slot_t [`FETCH_WIDTH-1:0] fetch_bundle_t;  // Index 0 is oldest

    // Resolved branch from the back end
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
    } bp_update_t;

    //////////////////////////////
    // Memory port

    typedef logic [31:0]                      mem_req_t;   // Line aligned address
    typedef logic [`ICACHE_LINE_BYTES*8-1:0]  mem_line_t;

endpackage

/* fetch_stage.sv */
// Fetch stage top: PC register, slot extraction, decoders, taken-branch cut, next-PC select
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_stage import fetch_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    // Dispatch side
    input  logic          dispatch_ready,
    output logic          fetch_valid,
    output fetch_bundle_t bundle,
    // Back end redirect and training
    input  logic          mispredict,
    input  addr_t         redirect_pc,
    input  bp_update_t    bp_update,
    // Line refill port
    output logic          mem_req_valid,
    output mem_req_t      mem_req,
    input  logic          mem_req_ready,
    input  logic          mem_resp_valid,
    input  mem_line_t     mem_resp_data
);
    localparam int W        = `FETCH_WIDTH;
    localparam int OFF_BITS = $clog2(`ICACHE_LINE_BYTES);
    localparam int CNT_BITS = $clog2(`FETCH_WIDTH + 1);

    addr_t                pc_q;
    addr_t                next_pc;
    addr_t                seq_pc;       // Fall through past the words in this line
    mem_line_t            line_data;
    logic                 cache_hit;
    addr_t   [W-1:0]      slot_pc;
    inst_t   [W-1:0]      slot_inst;
    decode_t [W-1:0]      slot_dec;
    logic    [W-1:0]      in_line;
    logic    [W-1:0]      slot_valid;
    logic    [W-1:0]      cut_before;   // An older slot is a predicted-taken branch
    logic    [W-1:0]      taken_here;
    logic    [W-1:0]      pred_taken;
    addr_t   [W-1:0]      pred_target;
    logic [CNT_BITS-1:0]  line_slots;

    //////////////////////////////
    // Cache and predictor

    icache icache_i (
        .clock          (clock),
        .reset          (reset),
        .lookup_pc      (pc_q),
        .abort          (mispredict),   // Leave the old path's miss
        .line_data      (line_data),
        .hit            (cache_hit),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    branch_predictor branch_predictor_i (
        .clock       (clock),
        .reset       (reset),
        .query_pc    (slot_pc),
        .update      (bp_update),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

    assign fetch_valid = cache_hit && !mispredict;

    //////////////////////////////
    // Slots

    for (genvar k = 0; k < W; k++) begin : g_slot
        logic [OFF_BITS-2:0] word_pos;  // Word in line, top bit set past the line end
        inst_t               raw_word;

        assign word_pos       = {1'b0, pc_q[OFF_BITS-1:2]} + (OFF_BITS-1)'(k);
        assign in_line[k]     = !word_pos[OFF_BITS-2];
        assign raw_word       = line_data[{word_pos[OFF_BITS-3:0], 5'd0} +: 32];
        assign slot_pc[k]     = pc_q + addr_t'(4 * k);
        assign slot_valid[k]  = fetch_valid && in_line[k] && !cut_before[k];
        assign slot_inst[k]   = slot_valid[k] ? raw_word : `NOP_INST;  // Empty slots get NOP

        inst_decoder inst_decoder_i (
            .inst   (slot_inst[k]),
            .decode (slot_dec[k])
        );

        assign taken_here[k] = slot_valid[k] && pred_taken[k] &&
                               (slot_dec[k].cond_branch || slot_dec[k].uncond_branch);

        if (k == 0) begin : g_oldest
            assign cut_before[k] = 1'b0;
        end else begin : g_younger
            assign cut_before[k] = cut_before[k-1] || taken_here[k-1];
        end

        assign bundle[k].valid  = slot_valid[k];
        assign bundle[k].pc     = slot_pc[k];
        assign bundle[k].inst   = slot_inst[k];
        assign bundle[k].decode = slot_dec[k];
    end

    //////////////////////////////
    // Next PC

    always_comb begin
        line_slots = '0;
        for (int k = 0; k < W; k++) begin
            line_slots = line_slots + CNT_BITS'(in_line[k]);
        end
    end

    assign seq_pc = pc_q + addr_t'({line_slots, 2'b00});

    // Walk youngest to oldest so the first taken branch sets the target
    always_comb begin
        next_pc = seq_pc;
        for (int k = W - 1; k >= 0; k--) begin
            if (taken_here[k]) next_pc = pred_target[k];
        end
    end

    // PC holds while a bundle waits for dispatch or the line misses
    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (mispredict) begin
            pc_q <= redirect_pc;        // Redirect beats everything
        end else if (fetch_valid && dispatch_ready) begin
            pc_q <= next_pc;            // Bundle accepted
        end
    end

endmodule

/* icache.sv */
// Direct-mapped instruction cache: combinational lookup, miss FSM, line refill
`timescale 1ns/1ns
`include "fetch_consts.svh"

module icache import fetch_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  addr_t     lookup_pc,
    input  logic      abort,           // Drop a request not yet accepted
    output mem_line_t line_data,
    output logic      hit,
    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    input  logic      mem_req_ready,
    input  logic      mem_resp_valid,
    input  mem_line_t mem_resp_data
);
    localparam int OFF_BITS = $clog2(`ICACHE_LINE_BYTES);
    localparam int IDX_BITS = $clog2(`ICACHE_LINES);
    localparam int TAG_BITS = 32 - OFF_BITS - IDX_BITS;

    typedef enum logic [1:0] {
        S_IDLE,                        // Serving hits, watching for a miss
        S_REQ,                         // Request on the port, waiting for ready
        S_WAIT                         // Accepted, waiting for the line
    } state_e;

    state_e                   state_q;
    state_e                   state_d;
    logic [`ICACHE_LINES-1:0] line_valid;
    logic [TAG_BITS-1:0]      tag_mem  [`ICACHE_LINES];
    mem_line_t                data_mem [`ICACHE_LINES];
    logic [IDX_BITS-1:0]      look_idx;
    logic [TAG_BITS-1:0]      look_tag;
    logic [IDX_BITS-1:0]      fill_idx;
    mem_req_t                 miss_addr;   // Line address of the outstanding miss
    logic                     fill;

    //////////////////////////////
    // Lookup

    assign look_idx  = lookup_pc[OFF_BITS +: IDX_BITS];
    assign look_tag  = lookup_pc[31 -: TAG_BITS];
    assign hit       = line_valid[look_idx] && (tag_mem[look_idx] == look_tag);
    assign line_data = data_mem[look_idx];

    //////////////////////////////
    // Miss handling

    assign fill_idx      = miss_addr[OFF_BITS +: IDX_BITS];
    assign fill          = (state_q == S_WAIT) && mem_resp_valid;
    assign mem_req_valid = (state_q == S_REQ);
    assign mem_req       = miss_addr;      // Held constant through S_REQ

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (!hit && !abort) state_d = S_REQ;
            end
            S_REQ: begin
                if (mem_req_ready) state_d = S_WAIT;     // Accepted even if abort
                else if (abort)    state_d = S_IDLE;
            end
            S_WAIT: begin
                if (mem_resp_valid) state_d = S_IDLE;    // Refill lands regardless of abort
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) state_q <= S_IDLE;
        else       state_q <= state_d;
    end

    // Capture the missing line address on entry to S_REQ
    always_ff @(posedge clock) begin
        if (state_q == S_IDLE && state_d == S_REQ) begin
            miss_addr <= {lookup_pc[31:OFF_BITS], {OFF_BITS{1'b0}}};
        end
    end

    //////////////////////////////
    // Arrays

    always_ff @(posedge clock) begin
        if (reset)     line_valid           <= '0;   // Cold cache
        else if (fill) line_valid[fill_idx] <= 1'b1;
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            tag_mem[fill_idx]  <= miss_addr[31 -: TAG_BITS];
            data_mem[fill_idx] <= mem_resp_data;
        end
    end

endmodule

/* inst_decoder.sv */
// Partial RV32I decoder for one fetch slot
`timescale 1ns/1ns

module inst_decoder import fetch_pkg::*; (
    input  inst_t   inst,
    output decode_t decode
);
    // Major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_FENCE  = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // funct3 to ALU op, alt selects SUB or SRA
    function automatic alu_func_e arith_func(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        decode          = '0;          // No rd, no class flags
        decode.opa_sel  = OPA_ZERO;
        decode.opb_sel  = OPB_I_IMM;
        decode.alu_func = ALU_ADD;     // Address and link arithmetic
        case (opcode)
            OP_LUI: begin
                decode.opb_sel = OPB_U_IMM;
                decode.uses_rd = 1'b1;
            end
            OP_AUIPC: begin
                decode.opa_sel = OPA_PC;
                decode.opb_sel = OPB_U_IMM;
                decode.uses_rd = 1'b1;
            end
            OP_JAL: begin
                decode.opa_sel       = OPA_PC;
                decode.opb_sel       = OPB_J_IMM;
                decode.uses_rd       = 1'b1;
                decode.uncond_branch = 1'b1;
            end
            OP_JALR: begin
                decode.opa_sel       = OPA_RS1;
                decode.uses_rd       = 1'b1;
                decode.uncond_branch = 1'b1;
                decode.illegal       = (funct3 != 3'b000);
            end
            OP_BRANCH: begin
                decode.opa_sel     = OPA_PC;            // Target is PC relative
                decode.opb_sel     = OPB_B_IMM;
                decode.cond_branch = 1'b1;
                decode.illegal     = (funct3[2:1] == 2'b01);
            end
            OP_LOAD: begin
                decode.opa_sel = OPA_RS1;
                decode.uses_rd = 1'b1;
                decode.rd_mem  = 1'b1;
                decode.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OP_STORE: begin
                decode.opa_sel = OPA_RS1;
                decode.opb_sel = OPB_S_IMM;
                decode.wr_mem  = 1'b1;
                decode.illegal = funct3[2] || (funct3 == 3'b011);
            end
            OP_IMM: begin
                decode.opa_sel  = OPA_RS1;
                decode.uses_rd  = 1'b1;
                decode.alu_func = arith_func(funct3, (funct3 == 3'b101) && funct7[5]);
                // Shift amounts are five bits, upper funct7 must be clean
                decode.illegal  = (funct3 == 3'b001 && funct7 != 7'h00) ||
                                  (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'h00);
            end
            OP_REG: begin
                decode.opa_sel  = OPA_RS1;
                decode.opb_sel  = OPB_RS2;
                decode.uses_rd  = 1'b1;
                decode.alu_func = arith_func(funct3, funct7[5]);
                decode.mult     = (funct7 == 7'h01);   // M extension, not executed here
                decode.illegal  = !(funct7 == 7'h00 || funct7 == 7'h01 ||
                                    (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OP_FENCE: ;                                // Ordering only, no operands
            OP_SYSTEM: begin
                if (funct3 == 3'b000) begin
                    decode.halt    = 1'b1;             // ecall, ebreak
                    decode.illegal = (inst[31:21] != '0) || (inst[19:7] != '0);
                end else begin
                    decode.opa_sel = funct3[2] ? OPA_ZERO : OPA_RS1;   // csrr*i uses uimm
                    decode.uses_rd = 1'b1;
                    decode.csr_op  = 1'b1;
                    decode.illegal = (funct3 == 3'b100);
                end
            end
            default: decode.illegal = 1'b1;
        endcase

        if (decode.illegal) begin
            decode.uses_rd = 1'b0;
        end
        // Branches and stores read registers outside the operand selects
        decode.uses_rs1 = !decode.illegal && (decode.opa_sel == OPA_RS1 || decode.cond_branch);
        decode.uses_rs2 = !decode.illegal &&
                          (decode.opb_sel == OPB_RS2 || decode.wr_mem || decode.cond_branch);
        decode.rs1      = inst[19:15];
        decode.rs2      = inst[24:20];
        decode.rd       = decode.uses_rd ? inst[11:7] : '0;
    end

endmodule

/* list.f */
+incdir+.
fetch_pkg.sv
icache.sv
branch_predictor.sv
inst_decoder.sv
fetch_stage.sv
tb_fetch.sv

/* tb_fetch.sv */
// Fetch stage testbench with memory model, decode and test tables, compare tasks and watchdog
`timescale 1ns/1ns
`include "fetch_consts.svh"

module tb_fetch import fetch_pkg::*; ();
    localparam int NUM_TESTS   = 9;
    localparam int PROG_WORDS  = 64;              // 256 bytes of program
    localparam int WAIT_LIMIT  = 40;              // Cycles to wait for a bundle
    localparam int WATCHDOG_NS = (3 + NUM_TESTS * 60) * 20;

    // One row of the stimulus table
    typedef struct packed {
        logic                    redirect;        // Enter the row through a mispredict
        addr_t                   start_pc;
        logic [1:0]              n_updates;       // Taken updates applied before the row
        addr_t                   upd_pc;
        addr_t                   upd_target;
        logic [3:0]              hold;            // Stall cycles with the bundle valid
        logic [`FETCH_WIDTH-1:0] exp_valid;       // Bit k is slot k
        addr_t                   exp_next_pc;
        logic [1:0]              exp_reqs;        // Line requests seen during the row
        mem_req_t                exp_req;         // Address of the first one
    } test_row_t;

    logic          clock;
    logic          reset;
    logic          dispatch_ready;
    logic          fetch_valid;
    fetch_bundle_t bundle;
    logic          mispredict;
    addr_t         redirect_pc;
    bp_update_t    bp_update;
    logic          mem_req_valid;
    mem_req_t      mem_req;
    logic          mem_req_ready;
    logic          mem_resp_valid;
    mem_line_t     mem_resp_data;

    inst_t         prog [PROG_WORDS];
    inst_t         dec_inst [$];                  // Instruction column of the decode table
    decode_t       dec_exp [$];                   // Expected decode column
    test_row_t     tests [NUM_TESTS];
    mem_req_t      req_log [$];                   // Requests seen by the memory model
    integer        seed = 32'h722a;
    int            errors;
    int            passed;
    int            failed;

    fetch_stage fetch_stage_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_ready (dispatch_ready),
        .fetch_valid    (fetch_valid),
        .bundle         (bundle),
        .mispredict     (mispredict),
        .redirect_pc    (redirect_pc),
        .bp_update      (bp_update),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;                    // 20 ns period

    //////////////////////////////
    // Memory model

    function automatic mem_line_t read_line(input mem_req_t addr);
        int w;
        w = int'(addr >> 2) % PROG_WORDS;
        return {prog[w + 3], prog[w + 2], prog[w + 1], prog[w]};   // Word 0 in low bits
    endfunction

    // Accepts every request and answers 2 to 5 cycles later
    always begin : memory_model
        mem_req_t line_addr;
        int       delay;
        @(posedge clock);
        #10;
        if (!reset && mem_req_valid && mem_req_ready) begin
            line_addr = mem_req;
            req_log.push_back(line_addr);
            delay = 2 + int'($unsigned($random(seed)) % 4);
            repeat (delay) @(posedge clock);      // First edge accepts the request
            #2;
            mem_resp_data  = read_line(line_addr);
            mem_resp_valid = 1'b1;
            @(posedge clock);
            #2;
            mem_resp_valid = 1'b0;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("TB FAILED");
        $finish;
    end

    //////////////////////////////
    // Tables

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = 32'hBAD0_0000 | inst_t'(i * 4);   // Filler carries its byte address
        end
        prog[0]  = 32'h0050_0093;   // addi x1, x0, 5
        prog[1]  = 32'h0220_8E63;   // beq x1, x2, +0x3c
        prog[2]  = 32'h0020_A423;   // sw x2, 8(x1)
        prog[3]  = 32'h0040_A183;   // lw x3, 4(x1)
        prog[4]  = 32'h0020_8433;   // add x8, x1, x2
        prog[5]  = 32'h4020_84B3;   // sub x9, x1, x2
        prog[6]  = 32'h4030_D513;   // srai x10, x1, 3
        prog[16] = 32'h0000_82E7;   // jalr x5, 0(x1)
        prog[17] = 32'hFFFF_FFFF;   // Illegal
        prog[18] = 32'h0000_13B7;   // lui x7, 1
        prog[19] = 32'h4020_D633;   // sra x12, x1, x2
        prog[32] = 32'h0000_0073;   // ecall
        prog[33] = 32'h3000_9273;   // csrrw x4, mstatus, x1
        prog[34] = 32'h0220_8333;   // mul x6, x1, x2
    endtask

    // Flag bits {rs1 rs2 rd}_{ld st}_{br jmp}_{csr halt mul ill}
    function automatic decode_t dec(input opa_sel_e opa, input opb_sel_e opb,
                                    input alu_func_e alu, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input reg_idx_t rd,
                                    input logic [10:0] flags);
        decode_t d;
        d.opa_sel  = opa;
        d.opb_sel  = opb;
        d.alu_func = alu;
        {d.uses_rs1, d.uses_rs2, d.uses_rd} = flags[10:8];
        {d.rd_mem, d.wr_mem}                = flags[7:6];
        {d.cond_branch, d.uncond_branch}    = flags[5:4];
        {d.csr_op, d.halt, d.mult, d.illegal} = flags[3:0];
        d.rs1 = rs1;
        d.rs2 = rs2;
        d.rd  = rd;
        return d;
    endfunction

    task automatic add_decode(input inst_t inst, input decode_t d);
        dec_inst.push_back(inst);
        dec_exp.push_back(d);
    endtask

    task automatic load_decodes();
        add_decode(`NOP_INST,   dec(OPA_RS1,  OPB_I_IMM, ALU_ADD, 0, 0,  0,  11'b101_00_00_0000));
        add_decode(32'h0050_0093, dec(OPA_RS1, OPB_I_IMM, ALU_ADD, 0, 5, 1,  11'b101_00_00_0000));
        add_decode(32'h0220_8E63, dec(OPA_PC,  OPB_B_IMM, ALU_ADD, 1, 2, 0,  11'b110_00_10_0000));
        add_decode(32'h0020_A423, dec(OPA_RS1, OPB_S_IMM, ALU_ADD, 1, 2, 0,  11'b110_01_00_0000));
        add_decode(32'h0040_A183, dec(OPA_RS1, OPB_I_IMM, ALU_ADD, 1, 4, 3,  11'b101_10_00_0000));
        add_decode(32'h0020_8433, dec(OPA_RS1, OPB_RS2,   ALU_ADD, 1, 2, 8,  11'b111_00_00_0000));
        add_decode(32'h4020_84B3, dec(OPA_RS1, OPB_RS2,   ALU_SUB, 1, 2, 9,  11'b111_00_00_0000));
        add_decode(32'h4030_D513, dec(OPA_RS1, OPB_I_IMM, ALU_SRA, 1, 3, 10, 11'b101_00_00_0000));
        add_decode(32'h0000_82E7, dec(OPA_RS1, OPB_I_IMM, ALU_ADD, 1, 0, 5,  11'b101_00_01_0000));
        add_decode(32'hFFFF_FFFF, dec(OPA_ZERO, OPB_I_IMM, ALU_ADD, 31, 31, 0,
                                      11'b000_00_00_0001));      // No rd on illegal
        add_decode(32'h0000_13B7, dec(OPA_ZERO, OPB_U_IMM, ALU_ADD, 0, 0, 7, 11'b001_00_00_0000));
        add_decode(32'h4020_D633, dec(OPA_RS1, OPB_RS2,   ALU_SRA, 1, 2, 12, 11'b111_00_00_0000));
        add_decode(32'h0000_0073, dec(OPA_ZERO, OPB_I_IMM, ALU_ADD, 0, 0, 0, 11'b000_00_00_0100));
        add_decode(32'h3000_9273, dec(OPA_RS1, OPB_I_IMM, ALU_ADD, 1, 0, 4,  11'b101_00_00_1000));
        add_decode(32'h0220_8333, dec(OPA_RS1, OPB_RS2,   ALU_ADD, 1, 2, 6,  11'b111_00_00_0010));
    endtask

    // Columns are redirect, start, n_upd, upd_pc, upd_target, hold, valid, next, reqs, req
    task automatic load_tests();
        tests[0] = '{1'b0, 32'h00, 2'd0, 32'h0, 32'h00, 4'd0, 3'b111, 32'h0C, 2'd1, 32'h00};
        tests[1] = '{1'b1, 32'h00, 2'd0, 32'h0, 32'h00, 4'd0, 3'b111, 32'h0C, 2'd0, 32'h00};
        tests[2] = '{1'b1, 32'h08, 2'd0, 32'h0, 32'h00, 4'd0, 3'b011, 32'h10, 2'd0, 32'h00};
        tests[3] = '{1'b1, 32'h00, 2'd2, 32'h4, 32'h40, 4'd0, 3'b011, 32'h40, 2'd1, 32'h10};
        tests[4] = '{1'b0, 32'h40, 2'd0, 32'h0, 32'h00, 4'd0, 3'b111, 32'h4C, 2'd1, 32'h40};
        tests[5] = '{1'b1, 32'h80, 2'd0, 32'h0, 32'h00, 4'd0, 3'b111, 32'h8C, 2'd1, 32'h80};
        tests[6] = '{1'b1, 32'h10, 2'd0, 32'h0, 32'h00, 4'd4, 3'b111, 32'h1C, 2'd0, 32'h00};
        tests[7] = '{1'b1, 32'h04, 2'd0, 32'h0, 32'h00, 4'd0, 3'b001, 32'h40, 2'd0, 32'h00};
        tests[8] = '{1'b1, 32'h4C, 2'd0, 32'h0, 32'h00, 4'd1, 3'b001, 32'h50, 2'd0, 32'h00};
    endtask

    //////////////////////////////
    // Expected values and compares

    function automatic int find_decode(input inst_t inst);
        for (int i = 0; i < dec_inst.size(); i++) begin
            if (dec_inst[i] == inst) return i;
        end
        return -1;
    endfunction

    task automatic expect_slot(input logic valid, input addr_t pc, output fetch_slot_t slot);
        int idx;
        slot.valid = valid;
        slot.pc    = pc;
        slot.inst  = valid ? prog[int'(pc >> 2) % PROG_WORDS] : `NOP_INST;  // Empty slot is NOP
        idx = find_decode(slot.inst);
        if (idx < 0) begin
            errors++;
            $display("No expected decode listed for instruction %h", slot.inst);
            slot.decode = '0;
        end else begin
            slot.decode = dec_exp[idx];
        end
    endtask

    task automatic check_slot(input fetch_slot_t got, input fetch_slot_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got v=%0b pc=%h inst=%h dec=%h", $time, what,
                     got.valid, got.pc, got.inst, got.decode);
            $display("[FAIL] %0t ns: %s: exp v=%0b pc=%h inst=%h dec=%h", $time, what,
                     exp.valid, exp.pc, exp.inst, exp.decode);
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pc(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Inputs change 2 ns after the edge
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    //////////////////////////////
    // Test sequence

    initial begin : main
        test_row_t   row;
        fetch_slot_t exp_slot;
        fetch_slot_t held [`FETCH_WIDTH];
        int          errors_before;
        int          waited;
        reset          = 1'b1;
        dispatch_ready = 1'b0;
        mispredict     = 1'b0;
        redirect_pc    = '0;
        bp_update      = '0;
        mem_req_ready  = 1'b1;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        errors = 0;
        passed = 0;
        failed = 0;
        load_program();
        load_decodes();
        load_tests();
        repeat (3) @(posedge clock);
        #2;
        reset = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            row           = tests[t];
            errors_before = errors;
            req_log.delete();
            for (int u = 0; u < row.n_updates; u++) begin   // Train the predictor
                next_cycle();
                bp_update = '{valid: 1'b1, pc: row.upd_pc, taken: 1'b1, target: row.upd_target};
            end
            next_cycle();
            bp_update = '0;
            if (row.redirect) begin
                mispredict  = 1'b1;
                redirect_pc = row.start_pc;
                #8;
                check_flag(fetch_valid, 1'b0, "fetch_valid during mispredict");
                next_cycle();
                mispredict = 1'b0;
            end
            #8;
            waited = 0;
            while (!fetch_valid && waited < WAIT_LIMIT) begin   // Covers any refill
                next_cycle();
                #8;
                waited++;
            end
            if (!fetch_valid) begin
                errors++;
                $display("Test %0d timed out waiting for a valid bundle", t);
            end else begin
                for (int k = 0; k < `FETCH_WIDTH; k++) begin
                    expect_slot(row.exp_valid[k], row.start_pc + addr_t'(4 * k), exp_slot);
                    check_slot(bundle[k], exp_slot, $sformatf("test %0d slot %0d", t, k));
                    held[k] = exp_slot;
                end
                repeat (row.hold) begin                     // Stalled bundle must not move
                    next_cycle();
                    #8;
                    check_flag(fetch_valid, 1'b1, "fetch_valid while stalled");
                    for (int k = 0; k < `FETCH_WIDTH; k++) begin
                        check_slot(bundle[k], held[k], $sformatf("test %0d held slot %0d", t, k));
                    end
                end
                next_cycle();
                dispatch_ready = 1'b1;                      // Exactly one transfer
                #8;
                check_flag(fetch_valid, 1'b1, "fetch_valid at transfer");
                next_cycle();
                dispatch_ready = 1'b0;
                #8;
                check_pc(bundle[0].pc, row.exp_next_pc, $sformatf("test %0d next PC", t));
            end
            if (req_log.size() != row.exp_reqs) begin
                errors++;
                $display("[FAIL] %0t ns: test %0d: got %0d memory requests, expected %0d",
                         $time, t, req_log.size(), row.exp_reqs);
            end else if (row.exp_reqs != 0) begin
                check_mem_req(req_log[0], row.exp_req, $sformatf("test %0d request", t));
            end
            if (errors == errors_before) begin
                passed++;
                $display("Test %0d passed", t);
            end else begin
                failed++;
                $display("Test %0d failed with %0d errors", t, errors - errors_before);
            end
        end

        $display("Tests: %0d  passed: %0d  failed: %0d  errors: %0d",
                 NUM_TESTS, passed, failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
